//--- Bender.yml
package:
  name: band_doa

sources:
  - logic/doa_pkg.sv
  - logic/band_correlator.sv
  - logic/band_fifo.sv
  - logic/isqrt_seq.sv
  - logic/hermitian_eig2.sv
  - logic/band_doa_top.sv
  - target: test
    files:
      - test/band_doa_checker.sv
      - test/band_doa_tb.sv

//--- band_doa.f
logic/doa_pkg.sv
logic/band_correlator.sv
logic/band_fifo.sv
logic/isqrt_seq.sv
logic/hermitian_eig2.sv
logic/band_doa_top.sv
test/band_doa_checker.sv
test/band_doa_tb.sv

//--- logic/band_correlator.sv
`timescale 1ns/10ps

module band_correlator import doa_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  din_beat_t  din,
    input  logic       new_acc,
    output band_corr_t corr,
    output logic       corr_valid
);

    typedef struct packed {
        logic signed [acc_width-1:0] r11;
        logic signed [acc_width-1:0] r22;
        logic signed [acc_width-1:0] r12_re;
        logic signed [acc_width-1:0] r12_im;
    } acc_set_t;

    logic [$clog2(vector_len)-1:0] bin_cnt;    // bin position within the vector
    logic                          has_data;
    acc_set_t                      beat_sum;
    acc_set_t                      s1_sum;
    logic                          s1_valid;
    logic [band_w-1:0]             s1_band;
    acc_set_t                      acc [bands];
    acc_set_t                      shadow [bands];
    logic [band_w-1:0]             dump_cnt;
    logic                          dumping;

    // products of all bins in the beat, summed
    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < parallel; i++) begin
            beat_sum.r11 = beat_sum.r11 + din.re1[i] * din.re1[i]
                         + din.im1[i] * din.im1[i];
            beat_sum.r22 = beat_sum.r22 + din.re2[i] * din.re2[i]
                         + din.im2[i] * din.im2[i];
            // x1 * conj(x2)
            beat_sum.r12_re = beat_sum.r12_re + din.re1[i] * din.re2[i]
                            + din.im1[i] * din.im2[i];
            beat_sum.r12_im = beat_sum.r12_im + din.im1[i] * din.re2[i]
                            - din.re1[i] * din.im2[i];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bin_cnt <= '0;
            has_data <= 1'b0;
        end else if (new_acc) begin
            bin_cnt <= '0;
            has_data <= 1'b0;
        end else if (din.valid) begin
            bin_cnt <= bin_cnt + ($clog2(vector_len))'(parallel);   // wraps at vector end
            has_data <= 1'b1;
        end
    end

    // sample stage, band taken from the beat index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s1_band <= '0;
        end else begin
            s1_valid <= din.valid && !new_acc;
            s1_band <= band_w'(bin_cnt / (parallel * beats_per_band));
        end
    end

    always_ff @(posedge clk) begin
        s1_sum <= beat_sum;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < bands; b++)
                acc[b] <= '0;
        end else if (new_acc) begin
            for (int b = 0; b < bands; b++)
                acc[b] <= '0;                        // restart integration
        end else if (s1_valid) begin
            acc[s1_band].r11 <= acc[s1_band].r11 + s1_sum.r11;
            acc[s1_band].r22 <= acc[s1_band].r22 + s1_sum.r22;
            acc[s1_band].r12_re <= acc[s1_band].r12_re + s1_sum.r12_re;
            acc[s1_band].r12_im <= acc[s1_band].r12_im + s1_sum.r12_im;
        end
    end

    always_ff @(posedge clk) begin
        if (new_acc && has_data)
            shadow <= acc;
    end

    // one band per cycle after the dump
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dumping <= 1'b0;
            dump_cnt <= '0;
        end else if (new_acc && has_data) begin
            dumping <= 1'b1;
            dump_cnt <= '0;
        end else if (dumping) begin
            dump_cnt <= dump_cnt + 1'b1;
            if (dump_cnt == band_w'(bands - 1))
                dumping <= 1'b0;
        end
    end

    always_comb begin
        logic c11, c22, cre, cim;
        corr.r11 = sat_la(shadow[dump_cnt].r11 >>> acc_shift, c11);
        corr.r22 = sat_la(shadow[dump_cnt].r22 >>> acc_shift, c22);
        corr.r12_re = sat_la(shadow[dump_cnt].r12_re >>> acc_shift, cre);
        corr.r12_im = sat_la(shadow[dump_cnt].r12_im >>> acc_shift, cim);
        corr.band = dump_cnt;
        corr.sat = c11 | c22 | cre | cim;
    end

    assign corr_valid = dumping;

    // new_acc closes an integration on a vector boundary
    a_whole_vectors: assert property (@(posedge clk) disable iff (!arst_n)
        new_acc && has_data |-> bin_cnt == '0);

endmodule

//--- logic/band_doa_top.sv
`timescale 1ns/10ps

module band_doa_top import doa_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  din_beat_t   din,
    input  logic        new_acc,
    output doa_result_t res,
    output logic        res_valid,
    output logic        fifo_full
);

    band_corr_t corr;
    logic       corr_valid;
    band_corr_t head;
    logic       empty;
    logic       pop;

    // covariance per band, dumped on new_acc
    band_correlator u_corr (
        .clk        (clk),
        .arst_n     (arst_n),
        .din        (din),
        .new_acc    (new_acc),
        .corr       (corr),
        .corr_valid (corr_valid)
    );

    band_fifo u_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (corr_valid),   // no back-pressure upstream
        .wdata  (corr),
        .pop    (pop),
        .head   (head),
        .empty  (empty),
        .full   (fifo_full)
    );

    // one band at a time
    hermitian_eig2 u_eig (
        .clk       (clk),
        .arst_n    (arst_n),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .res       (res),
        .res_valid (res_valid)
    );

endmodule

//--- logic/band_fifo.sv
`timescale 1ns/10ps

module band_fifo import doa_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr,
    input  band_corr_t wdata,
    input  logic       pop,
    output band_corr_t head,
    output logic       empty,
    output logic       full
);

    band_corr_t                     mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0]  wptr;
    logic [$clog2(fifo_depth)-1:0]  rptr;
    logic [$clog2(fifo_depth):0]    count;
    logic                           push_ok;
    logic                           pop_ok;

    assign push_ok = wr && !full;    // write while full is lost
    assign pop_ok = pop && !empty;

    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wptr] <= wdata;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
        end else begin
            if (push_ok)
                wptr <= wptr + 1'b1;
            if (pop_ok)
                rptr <= rptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = mem[rptr];     // fall-through head
    assign empty = (count == '0);
    assign full = (count == ($clog2(fifo_depth)+1)'(fifo_depth));

    // solver must only pop a valid head
    a_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> !empty);

endmodule

//--- logic/doa_pkg.sv
package doa_pkg;

    // input format
    localparam int din_width = 16;
    localparam int parallel = 4;        // bins per beat
    localparam int vector_len = 64;     // fft bins per vector
    localparam int bands = 4;
    localparam int beats_per_band = vector_len / (parallel * bands);
    localparam int band_w = $clog2(bands);

    // correlator and solver widths
    localparam int acc_width = 48;
    localparam int acc_shift = 16;      // applied at dump time
    localparam int la_width = 24;
    localparam int dout_width = 26;
    localparam int fifo_depth = 8;

    typedef logic signed [din_width-1:0] sample_t;

    typedef struct packed {
        logic                   valid;
        sample_t [parallel-1:0] re1;     // antenna 1
        sample_t [parallel-1:0] im1;
        sample_t [parallel-1:0] re2;     // antenna 2
        sample_t [parallel-1:0] im2;
    } din_beat_t;

    typedef struct packed {
        logic signed [la_width-1:0] r11;
        logic signed [la_width-1:0] r22;
        logic signed [la_width-1:0] r12_re;
        logic signed [la_width-1:0] r12_im;
        logic [band_w-1:0]          band;
        logic                       sat;     // one of the four words clipped
    } band_corr_t;

    typedef struct packed {
        logic signed [dout_width-1:0] lamb1;
        logic signed [dout_width-1:0] lamb2;
        logic signed [dout_width-1:0] eigen1_y;
        logic signed [dout_width-1:0] eigen2_y;
        logic signed [dout_width-1:0] eigen_x;
        logic [band_w-1:0]            band;
        logic                         error;
    } doa_result_t;

    // clamp a shifted accumulator into la_width, flag when clipped
    function automatic logic signed [la_width-1:0] sat_la(
        input  logic signed [acc_width-1:0] value,
        output logic                        clip
    );
        logic [acc_width-la_width:0] top_bits;
        top_bits = value[acc_width-1:la_width-1];
        clip = !((&top_bits) || !(|top_bits));   // upper bits not all sign
        if (!clip)
            sat_la = value[la_width-1:0];
        else if (value[acc_width-1])
            sat_la = {1'b1, {(la_width-1){1'b0}}};
        else
            sat_la = {1'b0, {(la_width-1){1'b1}}};
    endfunction

endpackage

//--- logic/hermitian_eig2.sv
`timescale 1ns/10ps

module hermitian_eig2 import doa_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  band_corr_t  head,
    input  logic        empty,
    output logic        pop,
    output doa_result_t res,
    output logic        res_valid
);

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_disc,
        st_root,
        st_output
    } state_t;

    state_t                        state;
    band_corr_t                    op;           // operands of the band in flight
    logic signed [la_width:0]      sum_w;
    logic signed [la_width:0]      diff_w;
    logic signed [la_width-1:0]    t_q;
    logic signed [la_width-1:0]    h_q;
    logic [acc_width-1:0]          d;
    logic                          sq_start;
    logic                          sq_done;
    logic [la_width-1:0]           root;
    logic signed [dout_width-1:0]  s_w;
    logic signed [dout_width-1:0]  lamb1;
    logic signed [dout_width-1:0]  lamb2;

    assign pop = (state == st_idle) && !empty;

    assign sum_w = op.r11 + op.r22;
    assign diff_w = op.r11 - op.r22;

    // h^2 + |r12|^2, always non-negative
    assign d = h_q * h_q + op.r12_re * op.r12_re + op.r12_im * op.r12_im;
    assign sq_start = (state == st_disc);

    isqrt_seq u_isqrt (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (sq_start),
        .radicand (d),
        .root     (root),
        .done     (sq_done)
    );

    assign s_w = {{(dout_width-la_width){1'b0}}, root};
    assign lamb1 = t_q + s_w;
    assign lamb2 = t_q - s_w;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (!empty) state <= st_load;
                st_load: state <= st_disc;
                st_disc: state <= st_root;
                st_root: if (sq_done) state <= st_output;
                st_output: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            op <= head;
        if (state == st_load) begin
            t_q <= sum_w[la_width:1];    // (r11+r22)/2
            h_q <= diff_w[la_width:1];   // (r11-r22)/2
        end
        if (state == st_root && sq_done) begin
            res.lamb1 <= lamb1;
            res.lamb2 <= lamb2;
            res.eigen1_y <= lamb1 - op.r11;
            res.eigen2_y <= lamb2 - op.r11;
            res.eigen_x <= op.r12_re;
            res.band <= op.band;
            res.error <= op.sat;
        end
    end

    assign res_valid = (state == st_output);

    // no second pop until the result of the first has left, 27 cycles on
    a_pop_idle: assert property (@(posedge clk) disable iff (!arst_n)
        pop |=> (!pop [*26]) ##1 (res_valid && !pop));

endmodule

//--- logic/isqrt_seq.sv
`timescale 1ns/10ps

module isqrt_seq import doa_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic [acc_width-1:0] radicand,
    output logic [la_width-1:0]  root,
    output logic                 done
);

    logic [acc_width-1:0]         rad_q, rad_in, rad_nx;
    logic [la_width+1:0]          rem_q, rem_in, rem_nx;
    logic [la_width-1:0]          root_q, root_in, root_nx;
    logic [la_width+3:0]          rem_sh, trial, diff;
    logic [$clog2(la_width)-1:0]  cnt;
    logic                         busy;

    // one restoring step, the start cycle already does the first bit
    always_comb begin
        rad_in = start ? radicand : rad_q;
        rem_in = start ? '0 : rem_q;
        root_in = start ? '0 : root_q;
        rem_sh = {rem_in, rad_in[acc_width-1 -: 2]};
        trial = {2'b00, root_in, 2'b01};     // 4*root + 1
        diff = rem_sh - trial;
        if (rem_sh >= trial) begin
            rem_nx = diff[la_width+1:0];
            root_nx = {root_in[la_width-2:0], 1'b1};
        end else begin
            rem_nx = rem_sh[la_width+1:0];
            root_nx = {root_in[la_width-2:0], 1'b0};
        end
        rad_nx = rad_in << 2;
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            rad_q <= rad_nx;
            rem_q <= rem_nx;
            root_q <= root_nx;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt <= '0;
            done <= 1'b0;
        end else begin
            done <= busy && (cnt == 1);    // last bit settles now
            if (start && !busy) begin
                busy <= 1'b1;
                cnt <= ($clog2(la_width))'(la_width - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == 1)
                    busy <= 1'b0;
            end
        end
    end

    assign root = root_q;

endmodule

//--- test/band_doa_checker.sv
`timescale 1ns/10ps

module band_doa_checker import doa_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  din_beat_t   din,
    input  logic        new_acc,
    input  doa_result_t res,
    input  logic        res_valid,
    input  logic        fifo_full,
    output int          outstanding,
    output int          err_cnt,
    output int          res_cnt
);

    longint      acc11 [bands];
    longint      acc22 [bands];
    longint      acc_re [bands];
    longint      acc_im [bands];
    int          beat_idx;       // beats since the last new_acc
    int          cb;
    bit          seen_beat;
    doa_result_t exp_q [$];
    doa_result_t exp_res;

    initial begin
        outstanding = 0;
        err_cnt = 0;
        res_cnt = 0;
    end

    // clamp to a signed la_width word
    function automatic longint clamp_la(input longint v, output bit clip);
        longint hi;
        hi = (longint'(1) << (la_width - 1)) - 1;
        clip = (v > hi) || (v < -hi - 1);
        if (v > hi)
            return hi;
        if (v < -hi - 1)
            return -hi - 1;
        return v;
    endfunction

    function automatic longint floor_sqrt(input longint d);
        longint r, c;
        r = 0;
        for (int b = la_width; b >= 0; b--) begin
            c = r + (longint'(1) << b);
            if (c * c <= d)
                r = c;
        end
        return r;
    endfunction

    // solver output for one band, from the raw band sums
    function automatic doa_result_t expected_result(input longint a11, input longint a22,
            input longint a_re, input longint a_im, input int band);
        longint      r11, r22, xre, xim, t, h, s;
        bit          c11, c22, cre, cim;
        doa_result_t e;
        r11 = clamp_la(a11 >>> acc_shift, c11);
        r22 = clamp_la(a22 >>> acc_shift, c22);
        xre = clamp_la(a_re >>> acc_shift, cre);
        xim = clamp_la(a_im >>> acc_shift, cim);
        t = (r11 + r22) >>> 1;
        h = (r11 - r22) >>> 1;
        s = floor_sqrt(h * h + xre * xre + xim * xim);
        e.lamb1 = dout_width'(t + s);
        e.lamb2 = dout_width'(t - s);
        e.eigen1_y = dout_width'(t + s - r11);
        e.eigen2_y = dout_width'(t - s - r11);
        e.eigen_x = dout_width'(xre);
        e.band = band_w'(band);
        e.error = c11 | c22 | cre | cim;
        return e;
    endfunction

    task automatic check_field(input string name, input longint exp_v, input longint got_v);
        if (exp_v != got_v) begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp_v, got_v);
            err_cnt++;
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            if (res_valid !== 1'b0 || fifo_full !== 1'b0) begin
                $display("res_valid or fifo_full not low during reset at %0t", $time);
                err_cnt++;
            end
            for (int b = 0; b < bands; b++) begin
                acc11[b] = 0;
                acc22[b] = 0;
                acc_re[b] = 0;
                acc_im[b] = 0;
            end
            beat_idx = 0;
            seen_beat = 1'b0;
            exp_q.delete();
            outstanding = 0;
        end else begin
            if (fifo_full) begin
                $display("FIFO went full at %0t, bands may be dropped", $time);
                err_cnt++;
            end
            if (res_valid && exp_q.size() == 0) begin
                $display("result for band %0d at %0t while none was expected", res.band, $time);
                err_cnt++;
            end else if (res_valid) begin
                exp_res = exp_q.pop_front();
                res_cnt++;
                check_field("lamb1", $signed(exp_res.lamb1), $signed(res.lamb1));
                check_field("lamb2", $signed(exp_res.lamb2), $signed(res.lamb2));
                check_field("eigen1_y", $signed(exp_res.eigen1_y), $signed(res.eigen1_y));
                check_field("eigen2_y", $signed(exp_res.eigen2_y), $signed(res.eigen2_y));
                check_field("eigen_x", $signed(exp_res.eigen_x), $signed(res.eigen_x));
                check_field("band", exp_res.band, res.band);
                check_field("error", exp_res.error, res.error);
            end
            if (new_acc) begin
                for (int b = 0; b < bands; b++) begin
                    if (seen_beat)     // empty integrations dump nothing
                        exp_q.push_back(expected_result(acc11[b], acc22[b], acc_re[b],
                                                        acc_im[b], b));
                    acc11[b] = 0;
                    acc22[b] = 0;
                    acc_re[b] = 0;
                    acc_im[b] = 0;
                end
                beat_idx = 0;
                seen_beat = 1'b0;
            end else if (din.valid) begin
                cb = (beat_idx / beats_per_band) % bands;     // band follows beats, not cycles
                for (int i = 0; i < parallel; i++) begin
                    acc11[cb] += din.re1[i] * din.re1[i] + din.im1[i] * din.im1[i];
                    acc22[cb] += din.re2[i] * din.re2[i] + din.im2[i] * din.im2[i];
                    acc_re[cb] += din.re1[i] * din.re2[i] + din.im1[i] * din.im2[i];
                    acc_im[cb] += din.im1[i] * din.re2[i] - din.re1[i] * din.im2[i];
                end
                beat_idx++;
                seen_beat = 1'b1;
            end
            outstanding = exp_q.size();
        end
    end

endmodule

//--- test/band_doa_tb.sv
`timescale 1ns/10ps

module band_doa_tb import doa_pkg::*; ;

    logic        clk;
    logic        arst_n;
    din_beat_t   din;
    logic        new_acc;
    doa_result_t res;
    logic        res_valid;
    logic        fifo_full;
    int          outstanding;
    int          err_cnt;
    int          res_cnt;
    int          tb_errs;        // timeouts and missing results
    logic [31:0] lfsr;

    band_doa_top DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .din       (din),
        .new_acc   (new_acc),
        .res       (res),
        .res_valid (res_valid),
        .fifo_full (fifo_full)
    );

    band_doa_checker u_check (
        .clk         (clk),
        .arst_n      (arst_n),
        .din         (din),
        .new_acc     (new_acc),
        .res         (res),
        .res_valid   (res_valid),
        .fifo_full   (fifo_full),
        .outstanding (outstanding),
        .err_cnt     (err_cnt),
        .res_cnt     (res_cnt)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic sample_t rand_sample(input int w, input bit full_scale);
        sample_t s;
        if (full_scale)
            return rand_bits(1) ? sample_t'(-32768) : sample_t'(32767);
        s = sample_t'(rand_bits(w) << (din_width - w));
        return s >>> (din_width - w);     // sign extend
    endfunction

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            din.valid = 1'b0;
            new_acc = 1'b0;
        end
    endtask

    task automatic send_vector(input int w, input bit gaps, input bit full_scale);
        for (int b = 0; b < vector_len / parallel; b++) begin
            if (gaps && rand_bits(2) == 0)
                drive_idle(rand_bits(2) + 1);
            @(negedge clk);
            din.valid = 1'b1;
            for (int i = 0; i < parallel; i++) begin
                din.re1[i] = rand_sample(w, full_scale);
                din.im1[i] = rand_sample(w, full_scale);
                din.re2[i] = rand_sample(w, full_scale);
                din.im2[i] = rand_sample(w, full_scale);
            end
        end
        @(negedge clk);
        din.valid = 1'b0;
    endtask

    task automatic pulse_new_acc();
        drive_idle(4);                  // last beat must settle first
        @(negedge clk);
        new_acc = 1'b1;
        @(negedge clk);
        new_acc = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (outstanding != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (outstanding != 0) begin
            $display("timeout after %0d cycles, %0d results never arrived", n, outstanding);
            tb_errs++;
        end
    endtask

    initial begin
        arst_n = 1'b0;
        din = '0;
        new_acc = 1'b0;
        lfsr = 32'h5d69_8692;
        tb_errs = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        pulse_new_acc();                // nothing accumulated yet
        drive_idle(40);
        send_vector(10, 1'b0, 1'b0);
        pulse_new_acc();
        wait_drain(200);
        // one integration of three vectors with gapped beats
        repeat (3)
            send_vector(12, 1'b1, 1'b0);
        pulse_new_acc();
        wait_drain(200);
        // full-scale samples, enough vectors for the band sums to clip
        repeat (20)
            send_vector(16, 1'b0, 1'b1);
        pulse_new_acc();
        wait_drain(200);
        repeat (10) begin
            send_vector(16, 1'b0, 1'b0);
            pulse_new_acc();
            drive_idle(100);            // four solver runs fit in the gap
        end
        wait_drain(400);
        if (res_cnt != 52) begin
            $display("expected 52 results in total, compared %0d", res_cnt);
            tb_errs++;
        end
        $display("results %0d, check errors %0d, testbench errors %0d",
                 res_cnt, err_cnt, tb_errs);
        if (err_cnt == 0 && tb_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
